//--- cmd_decoder.sv
/*
 * Command decoder
 * Accepts command words, holds vertex and colour registers and
 * launches draw, clear and swap
 */
`timescale 1ns/1ps
`include "gfx_settings.svh"

module cmd_decoder (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     cmd_valid_i,
    input  gfx_cmd_pkg::cmd_word_t   cmd_data_i,
    output logic                     cmd_ready_o,
    output logic                     swap_o,
    tri_setup_if.decoder             setup,
    output logic                     clear_start_o,
    output gfx_raster_pkg::color_t   clear_color_o,
    input  logic                     clear_done_i
);
    import gfx_cmd_pkg::*;

    dec_state_e state;
    opcode_e    op;
    payload_t   payload;
    logic       accept;

    assign op          = opcode_e'(cmd_data_i[`GFX_OP_POS +: `GFX_OP_BITS]);
    assign payload     = cmd_data_i[`GFX_PAYLOAD_BITS-1:0];
    assign cmd_ready_o = (state == DEC_IDLE);
    assign accept      = cmd_valid_i && cmd_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= DEC_IDLE;
            setup.start   <= 1'b0;
            clear_start_o <= 1'b0;
            swap_o        <= 1'b0;
        end else begin
            setup.start   <= 1'b0;
            clear_start_o <= 1'b0;
            swap_o        <= 1'b0;
            case (state)
                DEC_IDLE: begin
                    if (accept) begin
                        case (op)
                            CLEAR: begin
                                clear_start_o <= 1'b1;
                                state         <= DEC_BUSY;
                            end
                            DRAW: begin
                                setup.start <= 1'b1;
                                state       <= DEC_BUSY;
                            end
                            SWAP:    swap_o <= 1'b1;
                            default: ;
                        endcase
                    end
                end
                // only one of the two engines runs at a time
                DEC_BUSY: begin
                    if (setup.done || clear_done_i)
                        state <= DEC_IDLE;
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    // vertex and colour registers, only written while idle
    always_ff @(posedge clk) begin
        if (accept) begin
            case (op)
                SET_X0:    setup.x0 <= payload[11:0];
                SET_Y0:    setup.y0 <= payload[11:0];
                SET_X1:    setup.x1 <= payload[11:0];
                SET_Y1:    setup.y1 <= payload[11:0];
                SET_X2:    setup.x2 <= payload[11:0];
                SET_Y2:    setup.y2 <= payload[11:0];
                SET_COLOR: setup.color <= payload;
                CLEAR:     clear_color_o <= payload;
                default:   ;
            endcase
        end
    end

endmodule

//--- gfx_cmd_pkg.sv
/*
 * Command-side types
 * Opcodes, command word fields and the decoder state
 */
`include "gfx_settings.svh"

package gfx_cmd_pkg;

    typedef logic [`GFX_CMD_BITS-1:0]     cmd_word_t;
    typedef logic [`GFX_PAYLOAD_BITS-1:0] payload_t;

    // values outside this list are ignored by the decoder
    typedef enum logic [`GFX_OP_BITS-1:0] {
        SET_X0    = 4'd0,
        SET_Y0    = 4'd1,
        SET_X1    = 4'd2,
        SET_Y1    = 4'd3,
        SET_X2    = 4'd4,
        SET_Y2    = 4'd5,
        SET_COLOR = 4'd6,
        CLEAR     = 4'd7,
        DRAW      = 4'd8,
        SWAP      = 4'd9
    } opcode_e;

    typedef enum logic {
        DEC_IDLE,
        DEC_BUSY
    } dec_state_e;

endpackage

//--- gfx_core.sv
/*
 * Triangle filler top level
 * Command decoder, rasterizer and VRAM writer in a chain
 */
`timescale 1ns/1ps

module gfx_core (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         cmd_valid_i,
    input  gfx_cmd_pkg::cmd_word_t       cmd_data_i,
    output logic                         cmd_ready_o,
    output logic                         vram_wr_o,
    output gfx_raster_pkg::vram_addr_t   vram_addr_o,
    output gfx_raster_pkg::color_t       vram_data_o,
    output logic                         swap_o
);
    import gfx_raster_pkg::*;

    logic   clear_start;
    color_t clear_color;
    logic   clear_done;

    tri_setup_if setup ();
    pixel_if     pix ();

    cmd_decoder u_decoder (
        .clk           (clk),
        .reset_i       (reset_i),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_data_i    (cmd_data_i),
        .cmd_ready_o   (cmd_ready_o),
        .swap_o        (swap_o),
        .setup         (setup.decoder),
        .clear_start_o (clear_start),
        .clear_color_o (clear_color),
        .clear_done_i  (clear_done)
    );

    tri_rasterizer u_rasterizer (
        .clk     (clk),
        .reset_i (reset_i),
        .setup   (setup.raster),
        .pix     (pix.source)
    );

    vram_writer u_writer (
        .clk           (clk),
        .reset_i       (reset_i),
        .pix           (pix.sink),
        .clear_start_i (clear_start),
        .clear_color_i (clear_color),
        .clear_done_o  (clear_done),
        .vram_wr_o     (vram_wr_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_o   (vram_data_o)
    );

endmodule

//--- gfx_core_props.sv
/*
 * Bound checks on the triangle filler top level
 * Write address range, swap pulse width and ready during clear sweeps
 */
`timescale 1ns/1ps
`include "gfx_settings.svh"

module gfx_core_props (
    input logic                         clk,
    input logic                         reset_i,
    input logic                         cmd_ready_i,
    input logic                         swap_i,
    input logic                         vram_wr_i,
    input gfx_raster_pkg::vram_addr_t   vram_addr_i,
    input logic                         clear_start_i,
    input logic                         clear_done_i
);
    import gfx_raster_pkg::*;

    localparam vram_addr_t FB_PIXELS = vram_addr_t'(`GFX_FB_WIDTH * `GFX_FB_HEIGHT);

    logic sweep_active;

    // high from the first write of a clear sweep up to the one with clear_done
    always_ff @(posedge clk) begin
        if (reset_i)
            sweep_active <= 1'b0;
        else if (clear_start_i)
            sweep_active <= 1'b1;
        else if (clear_done_i)
            sweep_active <= 1'b0;
    end

    addr_in_range: assert property (@(posedge clk) disable iff (reset_i)
        vram_wr_i |-> (vram_addr_i < FB_PIXELS))
        else $error("VRAM write address outside the framebuffer");

    swap_single_cycle: assert property (@(posedge clk) disable iff (reset_i)
        swap_i |=> !swap_i)
        else $error("swap pulse longer than one cycle");

    ready_low_in_clear: assert property (@(posedge clk) disable iff (reset_i)
        (sweep_active && vram_wr_i) |-> !cmd_ready_i)
        else $error("command ready high during a clear sweep");

endmodule

//--- gfx_core_tb.sv
/*
 * Testbench for the triangle filler
 * Drives commands, mirrors VRAM writes into a framebuffer model and
 * compares it with a reference of the edge-function fill rule
 */
`timescale 1ns/1ps
`include "gfx_settings.svh"

module gfx_core_tb;
    import gfx_cmd_pkg::*;
    import gfx_raster_pkg::*;

    localparam int FB_W           = `GFX_FB_WIDTH;
    localparam int FB_H           = `GFX_FB_HEIGHT;
    localparam int FB_PIXELS      = FB_W * FB_H;
    localparam int NUM_RANDOM     = 20;
    localparam int NUM_CLEARS     = NUM_RANDOM + 2;
    localparam int NUM_DRAWS      = NUM_RANDOM + 2;
    localparam int TIMEOUT_CYCLES = (NUM_CLEARS + NUM_DRAWS) * FB_PIXELS * 4 + 2000;
    localparam logic [31:0] RAND_SEED = 32'hda530944;

    logic       clk;
    logic       reset_i;
    logic       cmd_valid_i;
    cmd_word_t  cmd_data_i;
    logic       cmd_ready_o;
    logic       vram_wr_o;
    vram_addr_t vram_addr_o;
    color_t     vram_data_o;
    logic       swap_o;

    // indexed by the full address type
    color_t     fb_model [0:65535];
    color_t     fb_expect [0:65535];

    int         vert [6];
    int         wr_count;
    int         swap_count;
    logic       in_clear;
    opcode_e    cmp_kind;
    color_t     cmp_color;
    event       compare_ev;

    gfx_core UUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_data_i  (cmd_data_i),
        .cmd_ready_o (cmd_ready_o),
        .vram_wr_o   (vram_wr_o),
        .vram_addr_o (vram_addr_o),
        .vram_data_o (vram_data_o),
        .swap_o      (swap_o)
    );

    bind gfx_core gfx_core_props u_props (
        .clk           (clk),
        .reset_i       (reset_i),
        .cmd_ready_i   (cmd_ready_o),
        .swap_i        (swap_o),
        .vram_wr_i     (vram_wr_o),
        .vram_addr_i   (vram_addr_o),
        .clear_start_i (clear_start),
        .clear_done_i  (clear_done)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("error: %0t ns %s", $time, msg));
    endtask

    task automatic check_color(input color_t got, input color_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s colour %h expected %h", what, got, exp));
    endtask

    task automatic check_addr(input vram_addr_t got, input vram_addr_t exp,
                              input string what);
        if (got !== exp)
            report_error($sformatf("%s %0d expected %0d", what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s %b expected %b", what, got, exp));
    endtask

    function automatic int min3(input int a, input int b, input int c);
        int m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic int max3(input int a, input int b, input int c);
        int m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // pixel is filled when it lies in the clipped box and on the inner side of all edges
    function automatic bit ref_inside(input int x, input int y, input int v[6]);
        int lo_x, hi_x, lo_y, hi_y;
        int w0, w1, w2;
        lo_x = max3(min3(v[0], v[2], v[4]), 0, 0);
        lo_y = max3(min3(v[1], v[3], v[5]), 0, 0);
        hi_x = min3(max3(v[0], v[2], v[4]), FB_W - 1, FB_W - 1);
        hi_y = min3(max3(v[1], v[3], v[5]), FB_H - 1, FB_H - 1);
        if (x < lo_x || x > hi_x || y < lo_y || y > hi_y)
            return 1'b0;
        w0 = (x - v[2]) * (v[5] - v[3]) - (y - v[3]) * (v[4] - v[2]);
        w1 = (x - v[4]) * (v[1] - v[5]) - (y - v[5]) * (v[0] - v[4]);
        w2 = (x - v[0]) * (v[3] - v[1]) - (y - v[1]) * (v[2] - v[0]);
        return (w0 >= 0) && (w1 >= 0) && (w2 >= 0);
    endfunction

    function automatic payload_t coord_payload(input int c);
        return payload_t'(c & 32'h0fff);
    endfunction

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_cmd(input opcode_e op, input payload_t payload);
        cmd_word_t word;
        while (!cmd_ready_o)
            @(negedge clk);
        word = '0;
        word[`GFX_OP_POS +: `GFX_OP_BITS] = op;
        word[`GFX_PAYLOAD_BITS-1:0] = payload;
        cmd_valid_i = 1'b1;
        cmd_data_i  = word;
        @(negedge clk);
        cmd_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (!cmd_ready_o)
            @(negedge clk);
    endtask

    task automatic run_compare();
        -> compare_ev;
        @(negedge clk);
    endtask

    task automatic do_clear(input color_t color);
        wr_count = 0;
        in_clear = 1'b1;
        send_cmd(CLEAR, color);
        wait_idle();
        in_clear = 1'b0;
        check_addr(vram_addr_t'(wr_count), vram_addr_t'(FB_PIXELS), "clear write count");
        cmp_kind  = CLEAR;
        cmp_color = color;
        run_compare();
    endtask

    task automatic do_draw(input color_t color);
        send_cmd(SET_X0, coord_payload(vert[0]));
        send_cmd(SET_Y0, coord_payload(vert[1]));
        send_cmd(SET_X1, coord_payload(vert[2]));
        send_cmd(SET_Y1, coord_payload(vert[3]));
        send_cmd(SET_X2, coord_payload(vert[4]));
        send_cmd(SET_Y2, coord_payload(vert[5]));
        send_cmd(SET_COLOR, color);
        send_cmd(DRAW, '0);
        wait_idle();
        cmp_kind  = DRAW;
        cmp_color = color;
        run_compare();
    endtask

    task automatic set_vertices(input int x0, input int y0, input int x1, input int y1,
                                input int x2, input int y2);
        vert[0] = x0;
        vert[1] = y0;
        vert[2] = x1;
        vert[3] = y1;
        vert[4] = x2;
        vert[5] = y2;
    endtask

    // mirror of every VRAM write, sampled away from the rising edge
    always @(negedge clk) begin
        if (swap_o === 1'b1)
            swap_count++;
        if (vram_wr_o === 1'b1) begin
            if (vram_addr_o >= vram_addr_t'(FB_PIXELS))
                report_error($sformatf("write to address %0d outside the framebuffer",
                                       vram_addr_o));
            if (in_clear)
                check_addr(vram_addr_o, vram_addr_t'(wr_count), "clear sweep address");
            fb_model[vram_addr_o] = vram_data_o;
            wr_count++;
        end
    end

    // expected framebuffer is advanced from the reference, then compared
    initial begin
        vram_addr_t idx;
        forever begin
            @(compare_ev);
            for (int y = 0; y < FB_H; y++) begin
                for (int x = 0; x < FB_W; x++) begin
                    idx = vram_addr_t'(y * FB_W + x);
                    if (cmp_kind == CLEAR || ref_inside(x, y, vert))
                        fb_expect[idx] = cmp_color;
                    check_color(fb_model[idx], fb_expect[idx],
                                $sformatf("pixel (%0d,%0d)", x, y));
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout: the run did not finish within %0d clock cycles",
                            TIMEOUT_CYCLES));
    end

    initial begin
        int area;
        int tmp;
        clk         = 1'b0;
        reset_i     = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_data_i  = '0;
        in_clear    = 1'b0;
        wr_count    = 0;
        swap_count  = 0;
        void'($urandom(RAND_SEED));
        repeat (4) @(negedge clk);
        reset_i = 1'b0;

        repeat (5) begin
            check_bit(cmd_ready_o, 1'b1, "ready after reset");
            check_bit(vram_wr_o, 1'b0, "VRAM write after reset");
            check_bit(swap_o, 1'b0, "swap after reset");
            @(negedge clk);
        end

        do_clear(color_t'($urandom));

        // counter-clockwise in screen coordinates, so the edge values are non-negative inside
        set_vertices(2, 2, 10, 27, 28, 6);
        do_draw(16'h07e0);

        check_bit(swap_o, 1'b0, "swap before the command");
        send_cmd(SWAP, '0);
        check_bit(swap_o, 1'b1, "swap in the cycle after acceptance");
        check_bit(cmd_ready_o, 1'b1, "ready during swap");
        @(negedge clk);
        check_bit(swap_o, 1'b0, "swap one cycle later");
        check_bit(cmd_ready_o, 1'b1, "ready after swap");

        do_clear(16'h001f);
        set_vertices(-6, -4, 12, 40, 40, 10);
        do_draw(16'hf800);

        for (int t = 0; t < NUM_RANDOM; t++) begin
            do_clear(color_t'($urandom));
            for (int i = 0; i < 6; i++)
                vert[i] = int'($urandom_range(47)) - 8;
            area = (vert[4] - vert[0]) * (vert[3] - vert[1])
                 - (vert[5] - vert[1]) * (vert[2] - vert[0]);
            // swap vertex 1 and 2 so most triangles cover pixels
            if (area < 0) begin
                tmp     = vert[2];
                vert[2] = vert[4];
                vert[4] = tmp;
                tmp     = vert[3];
                vert[3] = vert[5];
                vert[5] = tmp;
            end
            do_draw(color_t'($urandom));
        end

        check_addr(vram_addr_t'(swap_count), vram_addr_t'(1), "swap pulse count");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- gfx_ifaces.sv
/*
 * Interfaces between the triangle filler stages
 * tri_setup_if carries a draw request, pixel_if carries pixel hits
 */
`timescale 1ns/1ps

interface tri_setup_if;
    import gfx_raster_pkg::*;

    logic   start;
    logic   done;
    // held stable from start until done
    coord_t x0, y0, x1, y1, x2, y2;
    color_t color;

    modport decoder (output start, x0, y0, x1, y1, x2, y2, color, input done);
    modport raster (input start, x0, y0, x1, y1, x2, y2, color, output done);
endinterface

interface pixel_if;
    import gfx_raster_pkg::*;

    // no back-pressure, every valid cycle is taken
    logic   valid;
    coord_t x;
    coord_t y;
    color_t color;

    modport source (output valid, x, y, color);
    modport sink (input valid, x, y, color);
endinterface

//--- gfx_raster_pkg.sv
/*
 * Pixel-side types
 * Coordinates, edge values, colours, VRAM addresses and the
 * rasterizer and writer states
 */
package gfx_raster_pkg;

    // integer pixel coordinate, may be negative before clipping
    typedef logic signed [11:0] coord_t;

    // edge function result, sign tells the side of the edge
    typedef logic signed [31:0] edge_t;

    typedef logic [15:0] color_t;

    // y * width + x
    typedef logic [15:0] vram_addr_t;

    typedef enum logic [1:0] {
        RAST_IDLE,
        RAST_EVAL,
        RAST_TEST,
        RAST_FLUSH
    } rast_state_e;

    typedef enum logic {
        WR_IDLE,
        WR_CLEAR
    } wr_state_e;

endpackage

//--- gfx_settings.svh
/*
 * Triangle filler settings
 * Framebuffer size and command word layout
 */
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

// framebuffer size in pixels
`define GFX_FB_WIDTH  32
`define GFX_FB_HEIGHT 32

// command word layout
`define GFX_CMD_BITS     32
`define GFX_OP_POS       28
`define GFX_OP_BITS      4
`define GFX_PAYLOAD_BITS 16

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the triangle filler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module gfx_core_tb -f sim.f
./obj_dir/Vgfx_core_tb 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "run ended without a result, see sim.log"
    exit 1
fi

//--- sim.f
+incdir+.
gfx_cmd_pkg.sv
gfx_raster_pkg.sv
gfx_ifaces.sv
cmd_decoder.sv
tri_rasterizer.sv
vram_writer.sv
gfx_core.sv
gfx_core_props.sv
gfx_core_tb.sv

//--- tri_rasterizer.sv
/*
 * Triangle rasterizer
 * Clips the bounding box, scans it and emits pixels that pass
 * all three edge tests, two cycles per pixel
 */
`timescale 1ns/1ps
`include "gfx_settings.svh"

module tri_rasterizer (
    input  logic         clk,
    input  logic         reset_i,
    tri_setup_if.raster  setup,
    pixel_if.source      pix
);
    import gfx_raster_pkg::*;

    localparam coord_t LAST_X = coord_t'(`GFX_FB_WIDTH - 1);
    localparam coord_t LAST_Y = coord_t'(`GFX_FB_HEIGHT - 1);

    rast_state_e state;
    coord_t      box_x0, box_y0, box_x1, box_y1;
    coord_t      min_x, max_x, max_y;
    coord_t      px, py;
    edge_t       w0, w1, w2;
    logic        box_empty;
    logic        hit;
    logic        last;

    function automatic coord_t min2(input coord_t a, input coord_t b);
        return (a < b) ? a : b;
    endfunction

    function automatic coord_t max2(input coord_t a, input coord_t b);
        return (a > b) ? a : b;
    endfunction

    // edge from a to b evaluated at q
    function automatic edge_t edge_fn(input coord_t ax, input coord_t ay,
                                      input coord_t bx, input coord_t by,
                                      input coord_t qx, input coord_t qy);
        return (edge_t'(qx) - edge_t'(ax)) * (edge_t'(by) - edge_t'(ay))
             - (edge_t'(qy) - edge_t'(ay)) * (edge_t'(bx) - edge_t'(ax));
    endfunction

    // vertex bounding box clipped to the framebuffer
    assign box_x0 = max2(min2(min2(setup.x0, setup.x1), setup.x2), coord_t'(0));
    assign box_y0 = max2(min2(min2(setup.y0, setup.y1), setup.y2), coord_t'(0));
    assign box_x1 = min2(max2(max2(setup.x0, setup.x1), setup.x2), LAST_X);
    assign box_y1 = min2(max2(max2(setup.y0, setup.y1), setup.y2), LAST_Y);
    assign box_empty = (box_x0 > box_x1) || (box_y0 > box_y1);

    assign hit  = (w0 >= 0) && (w1 >= 0) && (w2 >= 0);
    assign last = (px == max_x) && (py == max_y);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= RAST_IDLE;
            setup.done <= 1'b0;
            pix.valid  <= 1'b0;
        end else begin
            setup.done <= 1'b0;
            pix.valid  <= 1'b0;
            case (state)
                RAST_IDLE: begin
                    if (setup.start) begin
                        if (box_empty)
                            setup.done <= 1'b1;
                        else
                            state <= RAST_EVAL;
                    end
                end
                RAST_EVAL: state <= RAST_TEST;
                RAST_TEST: begin
                    pix.valid <= hit;
                    state     <= last ? RAST_FLUSH : RAST_EVAL;
                end
                // one extra cycle so the writer has put out the last pixel
                RAST_FLUSH: begin
                    setup.done <= 1'b1;
                    state      <= RAST_IDLE;
                end
                default: state <= RAST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            RAST_IDLE: begin
                if (setup.start) begin
                    min_x <= box_x0;
                    max_x <= box_x1;
                    max_y <= box_y1;
                    px    <= box_x0;
                    py    <= box_y0;
                end
            end
            RAST_EVAL: begin
                w0 <= edge_fn(setup.x1, setup.y1, setup.x2, setup.y2, px, py);
                w1 <= edge_fn(setup.x2, setup.y2, setup.x0, setup.y0, px, py);
                w2 <= edge_fn(setup.x0, setup.y0, setup.x1, setup.y1, px, py);
            end
            RAST_TEST: begin
                pix.x     <= px;
                pix.y     <= py;
                pix.color <= setup.color;
                if (px == max_x) begin
                    px <= min_x;
                    py <= py + coord_t'(1);
                end else begin
                    px <= px + coord_t'(1);
                end
            end
            default: ;
        endcase
    end

endmodule

//--- vram_writer.sv
/*
 * VRAM writer
 * Turns pixel hits and clear sweeps into single-cycle VRAM writes
 */
`timescale 1ns/1ps
`include "gfx_settings.svh"

module vram_writer (
    input  logic                         clk,
    input  logic                         reset_i,
    pixel_if.sink                        pix,
    input  logic                         clear_start_i,
    input  gfx_raster_pkg::color_t       clear_color_i,
    output logic                         clear_done_o,
    output logic                         vram_wr_o,
    output gfx_raster_pkg::vram_addr_t   vram_addr_o,
    output gfx_raster_pkg::color_t       vram_data_o
);
    import gfx_raster_pkg::*;

    localparam vram_addr_t LAST_ADDR = vram_addr_t'(`GFX_FB_WIDTH * `GFX_FB_HEIGHT - 1);

    wr_state_e  state;
    vram_addr_t pixel_addr;

    assign pixel_addr = vram_addr_t'(pix.y) * vram_addr_t'(`GFX_FB_WIDTH)
                      + vram_addr_t'(pix.x);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= WR_IDLE;
            vram_wr_o    <= 1'b0;
            clear_done_o <= 1'b0;
        end else begin
            vram_wr_o    <= 1'b0;
            clear_done_o <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (clear_start_i) begin
                        state     <= WR_CLEAR;
                        vram_wr_o <= 1'b1;
                    end else if (pix.valid) begin
                        vram_wr_o <= 1'b1;
                    end
                end
                WR_CLEAR: begin
                    if (vram_addr_o != LAST_ADDR) begin
                        vram_wr_o    <= 1'b1;
                        // done goes out together with the last write
                        clear_done_o <= (vram_addr_o == LAST_ADDR - vram_addr_t'(1));
                    end else begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // the address register doubles as the sweep counter
    always_ff @(posedge clk) begin
        if (state == WR_CLEAR) begin
            vram_addr_o <= vram_addr_o + vram_addr_t'(1);
        end else if (clear_start_i) begin
            vram_addr_o <= '0;
            vram_data_o <= clear_color_i;
        end else if (pix.valid) begin
            vram_addr_o <= pixel_addr;
            vram_data_o <= pix.color;
        end
    end

endmodule
